/* cpu_alu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_alu (
	input  cpu_pkg::opcode_e op_i,
	input  cpu_pkg::cond_e   cond_i,
	input  cpu_pkg::word_t   a_i,
	input  cpu_pkg::word_t   b_i,
	input  cpu_pkg::flags_t  flags_i,
	output cpu_pkg::flags_t  flags_o,
	output cpu_pkg::word_t   result_o,
	output logic             taken_o
);

	localparam int MSB = `CPU_DATA_W - 1;

	logic [`CPU_DATA_W:0] sum;
	logic [`CPU_DATA_W:0] diff;
	cpu_pkg::word_t res;
	logic is_alu;
	logic ge;

	assign sum  = {1'b0, a_i} + {1'b0, b_i};
	assign diff = {1'b0, a_i} - {1'b0, b_i};	// top bit is the borrow
	assign is_alu = op_i inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
		cpu_pkg::OP_OR, cpu_pkg::OP_EOR, cpu_pkg::OP_CMP};

	always_comb begin
		res = '0;
		flags_o = flags_i;	// logic ops keep C and V
		case (op_i)
			cpu_pkg::OP_ADD: begin
				res = sum[MSB:0];
				flags_o.c = sum[`CPU_DATA_W];
				flags_o.v = (a_i[MSB] == b_i[MSB]) && (res[MSB] != a_i[MSB]);
			end
			cpu_pkg::OP_SUB, cpu_pkg::OP_CMP: begin
				res = diff[MSB:0];
				flags_o.c = ~diff[`CPU_DATA_W];	// set when no borrow
				flags_o.v = (a_i[MSB] != b_i[MSB]) && (res[MSB] != a_i[MSB]);
			end
			cpu_pkg::OP_AND: res = a_i & b_i;
			cpu_pkg::OP_OR:  res = a_i | b_i;
			cpu_pkg::OP_EOR: res = a_i ^ b_i;
			default: ;
		endcase
		if (is_alu) begin
			flags_o.n = res[MSB];
			flags_o.z = (res == '0);
		end
	end

	assign result_o = res;

	// ---------------------------------------------------------------------------
	// branch condition, evaluated on the flags currently held
	// ---------------------------------------------------------------------------
	assign ge = (flags_i.n == flags_i.v);

	always_comb begin
		case (cond_i)
			cpu_pkg::EQ: taken_o = flags_i.z;
			cpu_pkg::NE: taken_o = !flags_i.z;
			cpu_pkg::CS: taken_o = flags_i.c;
			cpu_pkg::CC: taken_o = !flags_i.c;
			cpu_pkg::MI: taken_o = flags_i.n;
			cpu_pkg::PL: taken_o = !flags_i.n;
			cpu_pkg::VS: taken_o = flags_i.v;
			cpu_pkg::VC: taken_o = !flags_i.v;
			cpu_pkg::HI: taken_o = flags_i.c && !flags_i.z;
			cpu_pkg::LS: taken_o = !flags_i.c || flags_i.z;
			cpu_pkg::GE: taken_o = ge;
			cpu_pkg::LT: taken_o = !ge;
			cpu_pkg::GT: taken_o = ge && !flags_i.z;
			cpu_pkg::LE: taken_o = flags_i.z || !ge;
			cpu_pkg::RA: taken_o = 1'b1;
			default:     taken_o = 1'b0;	// NV
		endcase
	end

endmodule

/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// ---------------------------------------------------------------------------
// core sizing
// ---------------------------------------------------------------------------
`define CPU_DATA_W	32	// word, address and bus width
`define CPU_NREGS	16	// register file depth, r0 reads as zero

// first fetch address after reset
`define CPU_RESET_PC	32'h0000_0000

// ---------------------------------------------------------------------------
// values parked on the bus outputs while no cycle is running
// ---------------------------------------------------------------------------
`define CPU_IDLE_ADR	32'h0000_0000
`define CPU_IDLE_DAT	32'h0000_0000

`endif

/* cpu_control.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_control (
	input  logic              clk,
	input  logic              rst_i,
	input  cpu_pkg::decoded_t dec_i,
	output cpu_pkg::word_t    insn_o,
	input  cpu_pkg::word_t    alu_result_i,
	input  cpu_pkg::flags_t   alu_flags_i,
	input  logic              taken_i,
	output cpu_pkg::flags_t   flags_o,
	input  cpu_pkg::word_t    rf_a_i,
	input  cpu_pkg::word_t    rf_t_i,
	output logic              rf_we_o,
	output cpu_pkg::reg_idx_t rf_wsel_o,
	output cpu_pkg::word_t    rf_wdata_o,
	output cpu_pkg::bus_req_t req_o,
	input  logic              done_i,
	input  cpu_pkg::word_t    rdata_i,
	output logic              halted_o
);

	cpu_pkg::cpu_state_e state;
	cpu_pkg::addr_t pc;
	cpu_pkg::word_t ir;
	cpu_pkg::flags_t flags;
	cpu_pkg::word_t imm_sx;
	cpu_pkg::addr_t mem_adr;
	logic is_alu;

	assign imm_sx  = {{(`CPU_DATA_W-16){dec_i.imm[15]}}, dec_i.imm};
	assign mem_adr = rf_a_i + imm_sx;	// ra + offset, stable through ST_MEM
	assign is_alu  = dec_i.op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
		cpu_pkg::OP_OR, cpu_pkg::OP_EOR, cpu_pkg::OP_CMP};

	// ---------------------------------------------------------------------------
	// instruction sequencing
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			state <= cpu_pkg::ST_FETCH;
			pc    <= `CPU_RESET_PC;
			flags <= '0;
		end else begin
			case (state)
				cpu_pkg::ST_FETCH:
					if (done_i)
						state <= cpu_pkg::ST_DECODE;
				cpu_pkg::ST_DECODE: begin
					pc    <= pc + 4;	// pc now points at the next instruction
					state <= cpu_pkg::ST_EXEC;
				end
				cpu_pkg::ST_EXEC: begin
					state <= cpu_pkg::ST_FETCH;
					if (is_alu) begin
						flags.n <= alu_flags_i.n;
						flags.z <= alu_flags_i.z;
						if (dec_i.sets_cv) begin
							flags.c <= alu_flags_i.c;
							flags.v <= alu_flags_i.v;
						end
					end
					case (dec_i.op)
						cpu_pkg::OP_LD, cpu_pkg::OP_ST: state <= cpu_pkg::ST_MEM;
						cpu_pkg::OP_BR:
							if (taken_i)
								pc <= pc + {imm_sx[`CPU_DATA_W-3:0], 2'b00};
						cpu_pkg::OP_WAI: state <= cpu_pkg::ST_HALT;
						default: ;
					endcase
				end
				cpu_pkg::ST_MEM:
					if (done_i)
						state <= cpu_pkg::ST_FETCH;
				default: state <= cpu_pkg::ST_HALT;	// stays until reset
			endcase
		end
	end

	// instruction register
	always_ff @(posedge clk) begin
		if (state == cpu_pkg::ST_FETCH && done_i)
			ir <= rdata_i;
	end

	// ---------------------------------------------------------------------------
	// register write and bus request
	// ---------------------------------------------------------------------------
	always_comb begin
		rf_we_o = 1'b0;
		if (state == cpu_pkg::ST_EXEC)
			rf_we_o = dec_i.writes_rt && dec_i.op != cpu_pkg::OP_LD;
		else if (state == cpu_pkg::ST_MEM)
			rf_we_o = done_i && dec_i.op == cpu_pkg::OP_LD;
	end

	assign rf_wsel_o = dec_i.rt;
	assign rf_wdata_o = (state == cpu_pkg::ST_MEM) ? rdata_i :
		(dec_i.op == cpu_pkg::OP_LDI) ? imm_sx : alu_result_i;

	always_comb begin
		req_o.valid = (state == cpu_pkg::ST_FETCH || state == cpu_pkg::ST_MEM) && !done_i;
		req_o.we    = (state == cpu_pkg::ST_MEM) && dec_i.op == cpu_pkg::OP_ST;
		req_o.adr   = (state == cpu_pkg::ST_MEM) ? mem_adr : pc;
		req_o.dat   = rf_t_i;	// store data from rt
	end

	assign insn_o   = ir;
	assign flags_o  = flags;
	assign halted_o = (state == cpu_pkg::ST_HALT);

	// halt is sticky and the bus stays quiet
	a_halt_quiet: assert property (@(posedge clk) disable iff (rst_i)
		(state == cpu_pkg::ST_HALT) |=> (state == cpu_pkg::ST_HALT) && !req_o.valid);

endmodule

/* cpu_decode.sv */
`timescale 1ns/1ps

module cpu_decode (
	input  cpu_pkg::word_t    insn_i,
	output cpu_pkg::decoded_t dec_o
);

	cpu_pkg::opcode_e op;

	// anything past the last defined opcode runs as a NOP
	always_comb begin
		if (insn_i[7:0] <= cpu_pkg::OP_WAI)
			op = cpu_pkg::opcode_e'(insn_i[7:0]);
		else
			op = cpu_pkg::OP_NOP;
	end

	always_comb begin
		dec_o.op   = op;
		dec_o.rt   = insn_i[11:8];
		dec_o.cond = cpu_pkg::cond_e'(insn_i[11:8]);	// same field, branch only
		dec_o.ra   = insn_i[15:12];
		dec_o.rb   = insn_i[19:16];
		dec_o.imm  = insn_i[31:16];	// overlaps rb, used by LDI/LD/ST/BR

		// CMP only touches the flags
		dec_o.writes_rt = op inside {cpu_pkg::OP_LDI, cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
			cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_EOR, cpu_pkg::OP_LD};

		dec_o.sets_cv = op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_CMP};
	end

endmodule

/* cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] word_t;
	typedef logic [`CPU_DATA_W-1:0] addr_t;	// byte address, word aligned on the bus
	typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;
	typedef logic [15:0] imm_t;

	typedef enum logic [7:0] {
		OP_NOP = 8'h00,
		OP_LDI = 8'h01,
		OP_ADD = 8'h02,
		OP_SUB = 8'h03,
		OP_AND = 8'h04,
		OP_OR  = 8'h05,
		OP_EOR = 8'h06,
		OP_CMP = 8'h07,
		OP_LD  = 8'h08,
		OP_ST  = 8'h09,
		OP_BR  = 8'h0A,
		OP_WAI = 8'h0B
	} opcode_e;

	// branch conditions, in rt field position of OP_BR
	typedef enum logic [3:0] {
		EQ, NE, CS, CC, MI, PL, VS, VC,
		HI, LS, GE, LT, GT, LE, RA, NV
	} cond_e;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flags_t;

	typedef struct packed {
		opcode_e  op;
		reg_idx_t rt;
		reg_idx_t ra;
		reg_idx_t rb;
		cond_e    cond;
		imm_t     imm;
		logic     writes_rt;
		logic     sets_cv;
	} decoded_t;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_EXEC,
		ST_MEM,
		ST_HALT
	} cpu_state_e;

	typedef struct packed {
		logic  valid;
		logic  we;
		addr_t adr;
		word_t dat;
	} bus_req_t;

endpackage

/* cpu_regfile.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_regfile (
	input  logic              clk,
	input  logic              rst_i,
	input  cpu_pkg::reg_idx_t ra_i,
	input  cpu_pkg::reg_idx_t rb_i,
	input  cpu_pkg::reg_idx_t rt_i,	// store data read and write target
	output cpu_pkg::word_t    rdata_a_o,
	output cpu_pkg::word_t    rdata_b_o,
	output cpu_pkg::word_t    rdata_t_o,
	input  logic              we_i,
	input  cpu_pkg::word_t    wdata_i
);

	cpu_pkg::word_t regs [`CPU_NREGS];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < `CPU_NREGS; i++)
				regs[i] <= '0;
		end else if (we_i && rt_i != '0) begin	// r0 is hardwired
			regs[rt_i] <= wdata_i;
		end
	end

	assign rdata_a_o = (ra_i == '0) ? '0 : regs[ra_i];
	assign rdata_b_o = (rb_i == '0) ? '0 : regs[rb_i];
	assign rdata_t_o = (rt_i == '0) ? '0 : regs[rt_i];

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
	input  logic           clk,
	input  logic           rst_i,
	output logic           cyc_o,
	output logic           stb_o,
	output logic           we_o,
	output cpu_pkg::addr_t adr_o,
	output cpu_pkg::word_t dat_o,
	input  logic           ack_i,
	input  cpu_pkg::word_t dat_i,
	output logic           halted_o
);

	cpu_pkg::decoded_t dec;
	cpu_pkg::word_t insn;
	cpu_pkg::word_t alu_result;
	cpu_pkg::flags_t alu_flags;
	cpu_pkg::flags_t flags;
	logic taken;
	cpu_pkg::word_t rf_a;
	cpu_pkg::word_t rf_b;
	cpu_pkg::word_t rf_t;
	logic rf_we;
	cpu_pkg::reg_idx_t rf_wsel;
	cpu_pkg::word_t rf_wdata;
	cpu_pkg::bus_req_t req;
	logic done;
	cpu_pkg::word_t rdata;

	cpu_control u_control (
		.clk(clk), .rst_i(rst_i), .dec_i(dec), .insn_o(insn),
		.alu_result_i(alu_result), .alu_flags_i(alu_flags), .taken_i(taken),
		.flags_o(flags), .rf_a_i(rf_a), .rf_t_i(rf_t), .rf_we_o(rf_we),
		.rf_wsel_o(rf_wsel), .rf_wdata_o(rf_wdata), .req_o(req),
		.done_i(done), .rdata_i(rdata), .halted_o(halted_o)
	);

	cpu_decode u_decode (.insn_i(insn), .dec_o(dec));

	cpu_regfile u_regfile (
		.clk(clk), .rst_i(rst_i), .ra_i(dec.ra), .rb_i(dec.rb), .rt_i(rf_wsel),
		.rdata_a_o(rf_a), .rdata_b_o(rf_b), .rdata_t_o(rf_t),
		.we_i(rf_we), .wdata_i(rf_wdata)
	);

	cpu_alu u_alu (
		.op_i(dec.op), .cond_i(dec.cond), .a_i(rf_a), .b_i(rf_b),
		.flags_i(flags), .flags_o(alu_flags), .result_o(alu_result), .taken_o(taken)
	);

	cpu_wb_master u_wb (
		.clk(clk), .rst_i(rst_i), .req_i(req), .done_o(done), .rdata_o(rdata),
		.cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o), .adr_o(adr_o), .dat_o(dat_o),
		.ack_i(ack_i), .dat_i(dat_i)
	);

endmodule

/* cpu_wb_master.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_wb_master (
	input  logic             clk,
	input  logic             rst_i,
	input  cpu_pkg::bus_req_t req_i,
	output logic             done_o,
	output cpu_pkg::word_t   rdata_o,
	output logic             cyc_o,
	output logic             stb_o,
	output logic             we_o,
	output cpu_pkg::addr_t   adr_o,
	output cpu_pkg::word_t   dat_o,
	input  logic             ack_i,
	input  cpu_pkg::word_t   dat_i
);

	// ---------------------------------------------------------------------------
	// one classic single-word cycle per request
	// ---------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			cyc_o  <= 1'b0;
			stb_o  <= 1'b0;
			we_o   <= 1'b0;
			done_o <= 1'b0;
			adr_o  <= `CPU_IDLE_ADR;
			dat_o  <= `CPU_IDLE_DAT;
		end else begin
			done_o <= 1'b0;
			if (cyc_o) begin
				if (ack_i) begin	// slave finished, close the cycle
					cyc_o  <= 1'b0;
					stb_o  <= 1'b0;
					we_o   <= 1'b0;
					done_o <= 1'b1;
				end
			end else if (req_i.valid && !done_o) begin
				cyc_o <= 1'b1;
				stb_o <= 1'b1;
				we_o  <= req_i.we;
				adr_o <= {req_i.adr[`CPU_DATA_W-1:2], 2'b00};	// always a full word
				dat_o <= req_i.dat;
			end
		end
	end

	// read data is valid alongside done_o
	always_ff @(posedge clk) begin
		if (cyc_o && ack_i)
			rdata_o <= dat_i;
	end

	a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst_i)
		stb_o |-> cyc_o);

	a_adr_hold: assert property (@(posedge clk) disable iff (rst_i)
		(stb_o && !ack_i) |=> $stable(adr_o));

endmodule

/* filelist.f */
+incdir+.
cpu_pkg.sv
cpu_wb_master.sv
cpu_decode.sv
cpu_regfile.sv
cpu_alu.sv
cpu_control.sv
cpu_top.sv
tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -f filelist.f \
	--top-module tb_cpu -Mdir obj_dir -o tb_cpu
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
exit 0

/* tb_cpu.sv */
`timescale 1ns/1ps
`include "cpu_config.svh"

module tb_cpu;

	localparam int MEM_WORDS    = 1024;	// 4 KB covering byte address bits 11:2
	localparam int WAIT_LIMIT   = 400;	// cycles allowed for any one event
	localparam int QUIET_CYCLES = 60;

	// compare ra with rb then branch on cond
	typedef struct packed {
		cpu_pkg::reg_idx_t ra;
		cpu_pkg::reg_idx_t rb;
		cpu_pkg::cond_e    cond;
		logic              taken;
	} br_case_t;

	logic clk;
	logic rst_i;
	logic cyc_o;
	logic stb_o;
	logic we_o;
	cpu_pkg::addr_t adr_o;
	cpu_pkg::word_t dat_o;
	logic ack_i;
	cpu_pkg::word_t dat_i;
	logic halted_o;

	cpu_pkg::word_t mem [MEM_WORDS];
	logic [9:0] load_at;
	cpu_pkg::addr_t exp_adr [$];	// expected writes in program order
	cpu_pkg::word_t exp_dat [$];
	cpu_pkg::addr_t wr_adr_q [$];	// writes seen on the bus
	cpu_pkg::word_t wr_dat_q [$];
	logic in_cycle;
	logic [1:0] wait_cnt;
	logic [15:0] lfsr;
	logic first_seen;
	cpu_pkg::addr_t first_adr;
	int errors = 0;
	int timeouts = 0;

	// r1 = -2, r2 = 0x1235, r11 = 0x7fffffff
	//   r2 - r2    n0 z1 c1 v0
	//   r1 - r2    n1 z0 c1 v0
	//   r2 - r1    n0 z0 c0 v0
	//   r11 - r1   n1 z0 c0 v1
	br_case_t br_cases [14] = '{
		{4'd2,  4'd2, cpu_pkg::EQ, 1'b1},
		{4'd2,  4'd2, cpu_pkg::NE, 1'b0},
		{4'd2,  4'd2, cpu_pkg::LE, 1'b1},
		{4'd2,  4'd2, cpu_pkg::GT, 1'b0},
		{4'd1,  4'd2, cpu_pkg::LT, 1'b1},	// signed -2 < 0x1235
		{4'd1,  4'd2, cpu_pkg::HI, 1'b1},	// unsigned the other way round
		{4'd1,  4'd2, cpu_pkg::CC, 1'b0},
		{4'd2,  4'd1, cpu_pkg::GT, 1'b1},
		{4'd2,  4'd1, cpu_pkg::LS, 1'b1},
		{4'd2,  4'd1, cpu_pkg::MI, 1'b0},
		{4'd11, 4'd1, cpu_pkg::VS, 1'b1},
		{4'd11, 4'd1, cpu_pkg::GE, 1'b1},	// overflow flips the sign
		{4'd11, 4'd1, cpu_pkg::LT, 1'b0},
		{4'd11, 4'd1, cpu_pkg::NV, 1'b0}
	};

	cpu_top dut (
		.clk(clk), .rst_i(rst_i), .cyc_o(cyc_o), .stb_o(stb_o), .we_o(we_o),
		.adr_o(adr_o), .dat_o(dat_o), .ack_i(ack_i), .dat_i(dat_i), .halted_o(halted_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic cpu_pkg::word_t enc_imm(input cpu_pkg::opcode_e op,
		input cpu_pkg::reg_idx_t rt, input cpu_pkg::reg_idx_t ra, input cpu_pkg::imm_t imm);
		return {imm, ra, rt, op};
	endfunction

	function automatic cpu_pkg::word_t enc_reg(input cpu_pkg::opcode_e op,
		input cpu_pkg::reg_idx_t rt, input cpu_pkg::reg_idx_t ra, input cpu_pkg::reg_idx_t rb);
		return {12'h000, rb, ra, rt, op};
	endfunction

	task automatic put_insn(input cpu_pkg::word_t insn);
		mem[load_at] = insn;
		load_at = load_at + 10'd1;
	endtask

	// ST rt, [ra + imm] and the write it must produce
	task automatic put_store(input cpu_pkg::reg_idx_t rt, input cpu_pkg::reg_idx_t ra,
		input cpu_pkg::imm_t imm, input cpu_pkg::addr_t ea, input cpu_pkg::word_t ed);
		put_insn(enc_imm(cpu_pkg::OP_ST, rt, ra, imm));
		exp_adr.push_back(ea);
		exp_dat.push_back(ed);
	endtask

	task automatic load_memory();
		cpu_pkg::addr_t a;
		cpu_pkg::imm_t slot;
		for (int i = 0; i < MEM_WORDS; i++) begin
			a = cpu_pkg::addr_t'(i) << 2;
			mem[10'(i)] = {~a[15:0], a[15:0]};
		end
		mem[10'h180] = 32'h7FFF_FFFF;	// data word at byte address 0x600
		load_at = '0;
		put_insn(enc_imm(cpu_pkg::OP_LDI, 4'd1, 4'd0, 16'hFFFE));
		put_insn(enc_imm(cpu_pkg::OP_LDI, 4'd2, 4'd0, 16'h1235));
		put_store(4'd1, 4'd0, 16'h0400, 32'h0000_0400, 32'hFFFF_FFFE);
		put_store(4'd2, 4'd1, 16'h0406, 32'h0000_0404, 32'h0000_1235);	// -2 + 0x406
		put_insn(enc_reg(cpu_pkg::OP_ADD, 4'd3, 4'd1, 4'd2));
		put_store(4'd3, 4'd0, 16'h0408, 32'h0000_0408, 32'h0000_1233);
		put_insn(enc_reg(cpu_pkg::OP_SUB, 4'd4, 4'd2, 4'd1));
		put_store(4'd4, 4'd0, 16'h040C, 32'h0000_040C, 32'h0000_1237);
		put_insn(enc_reg(cpu_pkg::OP_AND, 4'd5, 4'd1, 4'd2));
		put_store(4'd5, 4'd0, 16'h0410, 32'h0000_0410, 32'h0000_1234);
		put_insn(enc_reg(cpu_pkg::OP_OR, 4'd6, 4'd1, 4'd2));
		put_store(4'd6, 4'd0, 16'h0414, 32'h0000_0414, 32'hFFFF_FFFF);
		put_insn(enc_reg(cpu_pkg::OP_EOR, 4'd7, 4'd1, 4'd2));
		put_store(4'd7, 4'd0, 16'h0418, 32'h0000_0418, 32'hFFFF_EDCB);
		put_insn(enc_imm(cpu_pkg::OP_LD, 4'd11, 4'd0, 16'h0600));
		put_store(4'd11, 4'd0, 16'h041C, 32'h0000_041C, 32'h7FFF_FFFF);
		put_insn(enc_imm(cpu_pkg::OP_LD, 4'd0, 4'd0, 16'h0600));	// r0 keeps reading zero
		put_store(4'd0, 4'd0, 16'h0420, 32'h0000_0420, 32'h0000_0000);
		put_insn(enc_imm(cpu_pkg::OP_LDI, 4'd8, 4'd0, 16'h00AA));	// taken marker
		put_insn(enc_imm(cpu_pkg::OP_LDI, 4'd9, 4'd0, 16'h0055));	// not taken marker
		for (int i = 0; i < 14; i++) begin
			slot = 16'h0440 + 16'(4 * i);
			put_insn(enc_reg(cpu_pkg::OP_CMP, 4'd0, br_cases[4'(i)].ra, br_cases[4'(i)].rb));
			put_insn(enc_imm(cpu_pkg::OP_BR, cpu_pkg::reg_idx_t'(br_cases[4'(i)].cond),
				4'd0, 16'd2));
			put_insn(enc_imm(cpu_pkg::OP_ST, 4'd9, 4'd0, slot));
			put_insn(enc_imm(cpu_pkg::OP_BR, cpu_pkg::reg_idx_t'(cpu_pkg::RA), 4'd0, 16'd1));
			put_insn(enc_imm(cpu_pkg::OP_ST, 4'd8, 4'd0, slot));
			exp_adr.push_back(cpu_pkg::addr_t'(slot));
			exp_dat.push_back(br_cases[4'(i)].taken ? 32'h0000_00AA : 32'h0000_0055);
		end
		put_insn(enc_imm(cpu_pkg::OP_WAI, 4'd0, 4'd0, 16'h0000));
	endtask

	// ---------------------------------------------------------------------------
	// memory model as a classic single-word slave with random wait states
	// ---------------------------------------------------------------------------
	initial begin
		ack_i = 1'b0;
		dat_i = '0;
		in_cycle = 1'b0;
		first_seen = 1'b0;
		first_adr = '0;
		wait_cnt = 2'd0;
		lfsr = 16'd89;
		load_memory();
		forever begin
			@(posedge clk);
			#1;
			if (ack_i) begin
				ack_i = 1'b0;	// master closed the cycle on this edge
			end else if (cyc_o && stb_o) begin
				if (!in_cycle) begin
					in_cycle = 1'b1;
					if (!first_seen) begin
						first_adr = adr_o;
						first_seen = 1'b1;
					end
					for (int b = 0; b < 2; b++) begin	// two lfsr bits per access
						wait_cnt = {wait_cnt[0], lfsr[0]};
						lfsr = lfsr_next(lfsr);
					end
				end
				if (wait_cnt != 2'd0) begin
					wait_cnt = wait_cnt - 2'd1;
				end else begin
					in_cycle = 1'b0;
					ack_i = 1'b1;
					if (we_o) begin
						mem[adr_o[11:2]] = dat_o;
						wr_adr_q.push_back(adr_o);
						wr_dat_q.push_back(dat_o);
					end else begin
						dat_i = mem[adr_o[11:2]];
					end
				end
			end
		end
	end

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input cpu_pkg::addr_t got,
		input cpu_pkg::addr_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_word(input string name, input cpu_pkg::word_t got,
		input cpu_pkg::word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// ---------------------------------------------------------------------------
	// test sequence
	// ---------------------------------------------------------------------------
	task automatic run_tests();
		int t;
		check_bit("cyc_o", cyc_o, 1'b0);
		check_bit("stb_o", stb_o, 1'b0);
		check_bit("we_o", we_o, 1'b0);
		check_bit("halted_o", halted_o, 1'b0);	// low until the WAI executes
		t = 0;
		while (!first_seen && t < WAIT_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (!first_seen) begin
			$display("timeout: no fetch after reset");
			timeouts++;
			return;
		end
		check_addr("adr_o (first fetch)", first_adr, `CPU_RESET_PC);
		for (int i = 0; i < exp_adr.size(); i++) begin
			t = 0;
			while (wr_adr_q.size() <= i && t < WAIT_LIMIT) begin
				@(negedge clk);
				t++;
			end
			if (wr_adr_q.size() <= i) begin
				$display("timeout: write %0d of %0d never appeared", i, exp_adr.size());
				timeouts++;
				return;
			end
			check_addr($sformatf("adr_o (write %0d)", i), wr_adr_q[i], exp_adr[i]);
			check_word($sformatf("dat_o (write %0d)", i), wr_dat_q[i], exp_dat[i]);
		end
		t = 0;
		while (!halted_o && t < WAIT_LIMIT) begin
			@(negedge clk);
			t++;
		end
		if (!halted_o) begin
			$display("timeout: halted_o never rose after WAI");
			timeouts++;
			return;
		end
		for (int q = 0; q < QUIET_CYCLES; q++) begin
			@(negedge clk);
			if (cyc_o) begin
				$display("a bus cycle started while halted");
				errors++;
				return;
			end
		end
		check_bit("halted_o", halted_o, 1'b1);
		if (wr_adr_q.size() != exp_adr.size()) begin
			$display("%0d writes seen where %0d were expected", wr_adr_q.size(), exp_adr.size());
			errors++;
		end
	endtask

	initial begin
		rst_i = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		rst_i = 1'b0;
		run_tests();
		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
